// File: common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_r_type = 7'b0110011;

    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // shared by op-imm and R-type
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101; // bit 30 picks sra
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
        logic [31:0] raw;
    } rv_inst_t;

endpackage

`default_nettype wire

// File: common/id_ctrl_pkg.sv
`default_nettype none

package id_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add = 4'd0, // also the bubble value
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7,
        alu_sra = 4'd8,
        alu_beq = 4'd9,
        alu_bne = 4'd10,
        alu_bge = 4'd11,
        alu_blt = 4'd12,
        alu_lui = 4'd13
    } alu_op_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        wb_pc4 = 2'd0,
        wb_mem = 2'd1,
        wb_alu = 2'd2
    } wb_sel_t;

    typedef enum logic [1:0] {
        jmp_none = 2'b00,
        jmp_jump = 2'b10
    } jump_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      alu_src_a;  // 0 pc, 1 rs1
        logic      alu_src_b;  // 0 rs2, 1 imm
        wb_sel_t   mem_to_reg;
        jump_t     jump;
        alu_op_t   alu_op;
        mem_size_t inst_size;
        logic      is_signed;
    } id_ctrl_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_req_t;

    typedef struct packed {
        logic        valid;
        id_ctrl_t    ctrl;
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic [4:0]  rd;
    } id_ex_t;

endpackage

`default_nettype wire

// File: id_control/id_control.sv
`timescale 1ns/100ps
`default_nettype none

module id_control (
    input  rv_isa_pkg::rv_inst_t  inst,
    output id_ctrl_pkg::id_ctrl_t ctrl
);
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    wire [6:0] opcode = inst.r.opcode;
    wire [2:0] funct3 = inst.r.funct3;
    wire       bit30  = inst.r.funct7[5];

    wire lui   = (opcode == op_lui);
    wire auipc = (opcode == op_auipc);
    wire jal   = (opcode == op_jal);
    wire jalr  = (opcode == op_jalr);

    wire lb  = (opcode == op_load) && (funct3 == f3_lb);
    wire lh  = (opcode == op_load) && (funct3 == f3_lh);
    wire lw  = (opcode == op_load) && (funct3 == f3_lw);
    wire lbu = (opcode == op_load) && (funct3 == f3_lbu);
    wire lhu = (opcode == op_load) && (funct3 == f3_lhu);

    wire sb = (opcode == op_store) && (funct3 == f3_sb);
    wire sh = (opcode == op_store) && (funct3 == f3_sh);
    wire sw = (opcode == op_store) && (funct3 == f3_sw);

    wire beq  = (opcode == op_branch) && (funct3 == f3_beq);
    wire bne  = (opcode == op_branch) && (funct3 == f3_bne);
    wire blt  = (opcode == op_branch) && (funct3 == f3_blt);
    wire bge  = (opcode == op_branch) && (funct3 == f3_bge);
    wire bltu = (opcode == op_branch) && (funct3 == f3_bltu);
    wire bgeu = (opcode == op_branch) && (funct3 == f3_bgeu);

    wire addi  = (opcode == op_imm) && (funct3 == f3_add_sub);
    wire slti  = (opcode == op_imm) && (funct3 == f3_slt);
    wire sltiu = (opcode == op_imm) && (funct3 == f3_sltu);
    wire xori  = (opcode == op_imm) && (funct3 == f3_xor);
    wire ori   = (opcode == op_imm) && (funct3 == f3_or);
    wire andi  = (opcode == op_imm) && (funct3 == f3_and);
    wire slli  = (opcode == op_imm) && (funct3 == f3_sll);
    wire srli  = (opcode == op_imm) && (funct3 == f3_srl_sra) && !bit30;
    wire srai  = (opcode == op_imm) && (funct3 == f3_srl_sra) && bit30;

    wire add   = (opcode == op_r_type) && (funct3 == f3_add_sub) && !bit30;
    wire sub   = (opcode == op_r_type) && (funct3 == f3_add_sub) && bit30;
    wire slt   = (opcode == op_r_type) && (funct3 == f3_slt);
    wire sltu  = (opcode == op_r_type) && (funct3 == f3_sltu);
    wire xor_r = (opcode == op_r_type) && (funct3 == f3_xor);
    wire or_r  = (opcode == op_r_type) && (funct3 == f3_or);
    wire and_r = (opcode == op_r_type) && (funct3 == f3_and);
    wire sll   = (opcode == op_r_type) && (funct3 == f3_sll);
    wire srl   = (opcode == op_r_type) && (funct3 == f3_srl_sra) && !bit30;
    wire sra   = (opcode == op_r_type) && (funct3 == f3_srl_sra) && bit30;

    wire load   = lb || lh || lw || lbu || lhu;
    wire store  = sb || sh || sw;
    wire branch = beq || bne || blt || bge || bltu || bgeu;
    wire op_i   = addi || slti || sltiu || xori || ori || andi || slli || srli || srai;
    wire op_r   = add || sub || slt || sltu || xor_r || or_r || and_r || sll || srl || sra;
    wire known  = load || store || branch || op_i || op_r || lui || auipc || jal || jalr;

    always_comb begin
        ctrl = '0; // bubble unless matched
        if (load) begin
            ctrl.mem_read   = 1'b1;
            ctrl.reg_write  = 1'b1;
            ctrl.alu_src_a  = 1'b1;
            ctrl.alu_src_b  = 1'b1;
            ctrl.mem_to_reg = wb_mem;
        end else if (store) begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_src_a = 1'b1;
            ctrl.alu_src_b = 1'b1;
        end else if (branch) begin
            ctrl.alu_src_a = 1'b1; // rs1 vs rs2
        end else if (lui || auipc) begin
            ctrl.reg_write  = 1'b1;
            ctrl.alu_src_b  = 1'b1; // auipc keeps pc on a
            ctrl.mem_to_reg = wb_alu;
        end else if (jal || jalr) begin
            ctrl.reg_write  = 1'b1;
            ctrl.alu_src_a  = jalr;
            ctrl.alu_src_b  = 1'b1;
            ctrl.mem_to_reg = wb_pc4;
            ctrl.jump       = jmp_jump;
        end else if (op_i || op_r) begin
            ctrl.reg_write  = 1'b1;
            ctrl.alu_src_a  = 1'b1;
            ctrl.alu_src_b  = op_i;
            ctrl.mem_to_reg = wb_alu;
        end

        if (sub)                                   ctrl.alu_op = alu_sub;
        else if (andi || and_r)                    ctrl.alu_op = alu_and;
        else if (ori || or_r)                      ctrl.alu_op = alu_or;
        else if (xori || xor_r)                    ctrl.alu_op = alu_xor;
        else if (slti || sltiu || slt || sltu)     ctrl.alu_op = alu_slt;
        else if (slli || sll)                      ctrl.alu_op = alu_sll;
        else if (srli || srl)                      ctrl.alu_op = alu_srl;
        else if (srai || sra)                      ctrl.alu_op = alu_sra;
        else if (beq)                              ctrl.alu_op = alu_beq;
        else if (bne)                              ctrl.alu_op = alu_bne;
        else if (bge || bgeu)                      ctrl.alu_op = alu_bge;
        else if (blt || bltu)                      ctrl.alu_op = alu_blt;
        else if (lui)                              ctrl.alu_op = alu_lui;
        else                                       ctrl.alu_op = alu_add; // addr, pc, add

        if (known) begin
            if (lb || lbu || sb)      ctrl.inst_size = size_byte;
            else if (lh || lhu || sh) ctrl.inst_size = size_half;
            else                      ctrl.inst_size = size_word;
            ctrl.is_signed = !(lbu || lhu || sltu || sltiu || bltu || bgeu);
        end
    end

endmodule

`default_nettype wire

// File: rtl/id_imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module id_imm_gen (
    input  rv_isa_pkg::rv_inst_t inst,
    output logic [31:0]          imm
);
    import rv_isa_pkg::*;

    logic sign; // bit 31 in every format

    assign sign = inst.raw[31];

    always_comb begin
        imm = 32'd0; // R-type and unknown
        case (inst.i.opcode)
            op_load, op_jalr: begin
                imm = {{20{sign}}, inst.i.imm_11_0};
            end
            op_imm: begin
                if (inst.i.funct3 == f3_sll || inst.i.funct3 == f3_srl_sra) begin
                    imm = {27'd0, inst.r.rs2}; // shamt
                end else begin
                    imm = {{20{sign}}, inst.i.imm_11_0};
                end
            end
            op_store: begin
                imm = {{20{sign}}, inst.s.imm_11_5, inst.s.imm_4_0};
            end
            op_branch: begin
                imm = {{19{sign}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            end
            op_lui, op_auipc: begin
                imm = {inst.u.imm_31_12, 12'd0};
            end
            op_jal: begin
                imm = {{11{sign}}, inst.j.imm_20, inst.j.imm_19_12,
                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            end
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/id_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module id_reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  id_ctrl_pkg::wb_req_t wb,
    output logic [31:0]          rs1_data,
    output logic [31:0]          rs2_data
);
    logic [31:0] regs [1:31]; // x0 has no storage

    // same-cycle write is forwarded to the read
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        logic [31:0] data;
        if (addr == 5'd0) begin
            data = 32'd0;
        end else if (wb.we && wb.rd == addr) begin
            data = wb.data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb.we && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

`default_nettype wire

// File: rtl/id_ex_reg.sv
`timescale 1ns/100ps
`default_nettype none

module id_ex_reg (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  inst_valid,
    input  id_ctrl_pkg::id_ctrl_t ctrl,
    input  logic [31:0]           pc,
    input  logic [31:0]           rs1_data,
    input  logic [31:0]           rs2_data,
    input  logic [31:0]           imm,
    input  logic [4:0]            rd,
    output id_ctrl_pkg::id_ex_t   id_ex
);
    import id_ctrl_pkg::*;

    id_ex_t next_entry;

    always_comb begin
        next_entry = '0; // bubble
        if (flush) begin
            next_entry = '0; // wins over stall
        end else if (stall) begin
            next_entry = id_ex;
        end else if (inst_valid) begin
            next_entry.valid    = 1'b1;
            next_entry.ctrl     = ctrl;
            next_entry.pc       = pc;
            next_entry.rs1_data = rs1_data;
            next_entry.rs2_data = rs2_data;
            next_entry.imm      = imm;
            next_entry.rd       = rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            id_ex <= '0;
        end else begin
            id_ex <= next_entry;
        end
    end

endmodule

`default_nettype wire

// File: rtl/id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_isa_pkg::rv_inst_t inst,
    input  logic [31:0]          pc,
    input  logic                 inst_valid,
    input  logic                 stall,
    input  logic                 flush,
    input  id_ctrl_pkg::wb_req_t wb,
    output id_ctrl_pkg::id_ex_t  id_ex
);
    import id_ctrl_pkg::*;

    id_ctrl_t    ctrl;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    id_control u_control (
        .inst (inst),
        .ctrl (ctrl)
    );

    id_imm_gen u_imm_gen (
        .inst (inst),
        .imm  (imm)
    );

    id_reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (inst.r.rs1),
        .rs2      (inst.r.rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    id_ex_reg u_id_ex_reg (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .inst_valid (inst_valid),
        .ctrl       (ctrl),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .rd         (inst.r.rd),
        .id_ex      (id_ex)
    );

endmodule

`default_nettype wire

// File: tb/id_stage_vectors.svh
`ifndef ID_STAGE_VECTORS_SVH
`define ID_STAGE_VECTORS_SVH

// each row holds an instruction word, its pc, the expected ctrl and the expected imm
task automatic load_vectors();
    // loads
    add_row(enc_i(-4, 2, 3'b000, 5, op_load), 32'h100,
            ctl(1,0,1,1,1, wb_mem, jmp_none, alu_add, size_byte, 1), 32'hFFFF_FFFC);
    add_row(enc_i(8, 3, 3'b001, 6, op_load), 32'h104,
            ctl(1,0,1,1,1, wb_mem, jmp_none, alu_add, size_half, 1), 32'h8);
    add_row(enc_i(12, 4, 3'b010, 7, op_load), 32'h108,
            ctl(1,0,1,1,1, wb_mem, jmp_none, alu_add, size_word, 1), 32'hC);
    add_row(enc_i(1, 5, 3'b100, 8, op_load), 32'h10C,
            ctl(1,0,1,1,1, wb_mem, jmp_none, alu_add, size_byte, 0), 32'h1);
    add_row(enc_i(2, 6, 3'b101, 9, op_load), 32'h110,
            ctl(1,0,1,1,1, wb_mem, jmp_none, alu_add, size_half, 0), 32'h2);
    // stores
    add_row(enc_s(-8, 7, 8, 3'b000), 32'h114,
            ctl(0,1,0,1,1, wb_pc4, jmp_none, alu_add, size_byte, 1), 32'hFFFF_FFF8);
    add_row(enc_s(16, 9, 10, 3'b001), 32'h118,
            ctl(0,1,0,1,1, wb_pc4, jmp_none, alu_add, size_half, 1), 32'h10);
    add_row(enc_s(2047, 11, 12, 3'b010), 32'h11C,
            ctl(0,1,0,1,1, wb_pc4, jmp_none, alu_add, size_word, 1), 32'h7FF);
    // branches
    add_row(enc_b(-16, 13, 14, 3'b000), 32'h120,
            ctl(0,0,0,1,0, wb_pc4, jmp_none, alu_beq, size_word, 1), 32'hFFFF_FFF0);
    add_row(enc_b(32, 15, 16, 3'b001), 32'h124,
            ctl(0,0,0,1,0, wb_pc4, jmp_none, alu_bne, size_word, 1), 32'h20);
    add_row(enc_b(2048, 17, 18, 3'b100), 32'h128,
            ctl(0,0,0,1,0, wb_pc4, jmp_none, alu_blt, size_word, 1), 32'h800);
    add_row(enc_b(-4096, 19, 20, 3'b101), 32'h12C,
            ctl(0,0,0,1,0, wb_pc4, jmp_none, alu_bge, size_word, 1), 32'hFFFF_F000);
    add_row(enc_b(4, 21, 22, 3'b110), 32'h130,
            ctl(0,0,0,1,0, wb_pc4, jmp_none, alu_blt, size_word, 0), 32'h4);
    add_row(enc_b(2046, 23, 24, 3'b111), 32'h134,
            ctl(0,0,0,1,0, wb_pc4, jmp_none, alu_bge, size_word, 0), 32'h7FE);
    // upper immediates and jumps
    add_row(enc_u(20'hABCDE, 25, op_lui), 32'h138,
            ctl(0,0,1,0,1, wb_alu, jmp_none, alu_lui, size_word, 1), 32'hABCD_E000);
    add_row(enc_u(20'h80000, 26, op_auipc), 32'h13C,
            ctl(0,0,1,0,1, wb_alu, jmp_none, alu_add, size_word, 1), 32'h8000_0000);
    add_row(enc_j(-2048, 1), 32'h140,
            ctl(0,0,1,0,1, wb_pc4, jmp_jump, alu_add, size_word, 1), 32'hFFFF_F800);
    add_row(enc_j(32'h12344, 27), 32'h144,
            ctl(0,0,1,0,1, wb_pc4, jmp_jump, alu_add, size_word, 1), 32'h1_2344);
    add_row(enc_i(-1, 28, 3'b000, 0, op_jalr), 32'h148,
            ctl(0,0,1,1,1, wb_pc4, jmp_jump, alu_add, size_word, 1), 32'hFFFF_FFFF);
    // op-imm with an addi that reads x0
    add_row(enc_i(-100, 0, 3'b000, 29, op_imm), 32'h14C,
            ctl(0,0,1,1,1, wb_alu, jmp_none, alu_add, size_word, 1), 32'hFFFF_FF9C);
    add_row(enc_i(5, 30, 3'b010, 2, op_imm), 32'h150,
            ctl(0,0,1,1,1, wb_alu, jmp_none, alu_slt, size_word, 1), 32'h5);
    add_row(enc_i(7, 31, 3'b011, 3, op_imm), 32'h154,
            ctl(0,0,1,1,1, wb_alu, jmp_none, alu_slt, size_word, 0), 32'h7);
    add_row(enc_i(-1, 1, 3'b100, 4, op_imm), 32'h158,
            ctl(0,0,1,1,1, wb_alu, jmp_none, alu_xor, size_word, 1), 32'hFFFF_FFFF);
    add_row(enc_i(32'h123, 2, 3'b110, 5, op_imm), 32'h15C,
            ctl(0,0,1,1,1, wb_alu, jmp_none, alu_or, size_word, 1), 32'h123);
    add_row(enc_i(32'hFF, 3, 3'b111, 6, op_imm), 32'h160,
            ctl(0,0,1,1,1, wb_alu, jmp_none, alu_and, size_word, 1), 32'hFF);
    add_row(enc_i(7, 4, 3'b001, 7, op_imm), 32'h164,
            ctl(0,0,1,1,1, wb_alu, jmp_none, alu_sll, size_word, 1), 32'h7);
    add_row(enc_i(31, 5, 3'b101, 8, op_imm), 32'h168,
            ctl(0,0,1,1,1, wb_alu, jmp_none, alu_srl, size_word, 1), 32'h1F);
    add_row(enc_i(32'h403, 6, 3'b101, 9, op_imm), 32'h16C,
            ctl(0,0,1,1,1, wb_alu, jmp_none, alu_sra, size_word, 1), 32'h3);
    // R-type
    add_row(enc_r(7'h00, 1, 2, 3'b000, 3), 32'h170,
            ctl(0,0,1,1,0, wb_alu, jmp_none, alu_add, size_word, 1), 32'h0);
    add_row(enc_r(7'h20, 4, 5, 3'b000, 6), 32'h174,
            ctl(0,0,1,1,0, wb_alu, jmp_none, alu_sub, size_word, 1), 32'h0);
    add_row(enc_r(7'h00, 7, 8, 3'b001, 9), 32'h178,
            ctl(0,0,1,1,0, wb_alu, jmp_none, alu_sll, size_word, 1), 32'h0);
    add_row(enc_r(7'h00, 10, 11, 3'b010, 12), 32'h17C,
            ctl(0,0,1,1,0, wb_alu, jmp_none, alu_slt, size_word, 1), 32'h0);
    add_row(enc_r(7'h00, 13, 14, 3'b011, 15), 32'h180,
            ctl(0,0,1,1,0, wb_alu, jmp_none, alu_slt, size_word, 0), 32'h0);
    add_row(enc_r(7'h00, 16, 17, 3'b100, 18), 32'h184,
            ctl(0,0,1,1,0, wb_alu, jmp_none, alu_xor, size_word, 1), 32'h0);
    add_row(enc_r(7'h00, 19, 20, 3'b101, 21), 32'h188,
            ctl(0,0,1,1,0, wb_alu, jmp_none, alu_srl, size_word, 1), 32'h0);
    add_row(enc_r(7'h20, 22, 23, 3'b101, 24), 32'h18C,
            ctl(0,0,1,1,0, wb_alu, jmp_none, alu_sra, size_word, 1), 32'h0);
    add_row(enc_r(7'h00, 25, 26, 3'b110, 27), 32'h190,
            ctl(0,0,1,1,0, wb_alu, jmp_none, alu_or, size_word, 1), 32'h0);
    add_row(enc_r(7'h00, 28, 29, 3'b111, 30), 32'h194,
            ctl(0,0,1,1,0, wb_alu, jmp_none, alu_and, size_word, 1), 32'h0);
    // unknown opcodes decode to the all-zero control value
    add_row(32'h0041_80FF, 32'h198, 16'h0000, 32'h0);
    add_row(32'h0FF0_000F, 32'h19C, 16'h0000, 32'h0);
endtask

`endif

// File: tb/id_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage_tb;
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    logic     clk;
    logic     reset;
    rv_inst_t inst;
    logic     [31:0] pc;
    logic     inst_valid;
    logic     stall;
    logic     flush;
    wb_req_t  wb;
    id_ex_t   id_ex;

    logic [31:0] model [0:31];
    logic [31:0] vec_inst [$];
    logic [31:0] vec_pc [$];
    id_ctrl_t    vec_ctrl [$];
    logic [31:0] vec_imm [$];
    int          errors;
    int          checks;
    int          rise_count;
    int          fall_count;

    id_stage dut0 (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .pc         (pc),
        .inst_valid (inst_valid),
        .stall      (stall),
        .flush      (flush),
        .wb         (wb),
        .id_ex      (id_ex)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) rise_count++;
    always @(negedge clk) fall_count++;

    function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_r_type};
    endfunction

    function automatic id_ctrl_t ctl(logic mr, logic mw, logic rw, logic sa, logic sb,
                                     wb_sel_t w, jump_t j, alu_op_t op, mem_size_t sz,
                                     logic sg);
        return {mr, mw, rw, sa, sb, w, j, op, sz, sg};
    endfunction

    task automatic add_row(logic [31:0] word, logic [31:0] addr, id_ctrl_t c, logic [31:0] imm);
        vec_inst.push_back(word);
        vec_pc.push_back(addr);
        vec_ctrl.push_back(c);
        vec_imm.push_back(imm);
    endtask

    `include "id_stage_vectors.svh"

    // next rising or falling edge, then a short settle
    task automatic wait_edge(bit rising);
        int target;
        int t;
        t = 0;
        target = rising ? rise_count + 1 : fall_count + 1;
        while ((rising ? rise_count : fall_count) < target && t < 200) begin
            #1;
            t++;
        end
        if (t >= 200) begin
            $display("timeout: no clock edge seen within 200 ns");
            $display("test failed");
            $finish;
        end else begin
            #2;
        end
    endtask

    task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_entry(string tag, id_ex_t exp);
        check_field({tag, " valid"}, 32'(id_ex.valid), 32'(exp.valid));
        check_field({tag, " ctrl"}, 32'(id_ex.ctrl), 32'(exp.ctrl));
        check_field({tag, " pc"}, id_ex.pc, exp.pc);
        check_field({tag, " rs1_data"}, id_ex.rs1_data, exp.rs1_data);
        check_field({tag, " rs2_data"}, id_ex.rs2_data, exp.rs2_data);
        check_field({tag, " imm"}, id_ex.imm, exp.imm);
        check_field({tag, " rd"}, 32'(id_ex.rd), 32'(exp.rd));
    endtask

    function automatic id_ex_t expect_row(int n);
        id_ex_t e;
        e.valid    = 1'b1;
        e.ctrl     = vec_ctrl[n];
        e.pc       = vec_pc[n];
        e.rs1_data = model[vec_inst[n][19:15]]; // read ports see raw field bits
        e.rs2_data = model[vec_inst[n][24:20]];
        e.imm      = vec_imm[n];
        e.rd       = vec_inst[n][11:7];
        return e;
    endfunction

    initial begin
        id_ex_t      exp;
        logic [31:0] fresh;

        reset      = 1'b0;
        inst       = '0;
        pc         = 32'd0;
        inst_valid = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        wb         = '0;
        errors     = 0;
        checks     = 0;
        void'($urandom(32'h1362));
        load_vectors();

        inst.raw   = vec_inst[0];
        pc         = vec_pc[0];
        inst_valid = 1'b1; // live instruction held off by reset
        for (int i = 0; i < 10; i++) begin
            wait_edge(1);
            check_entry("reset", '0);
        end
        wait_edge(0);
        reset      = 1'b1;
        inst_valid = 1'b0;
        wait_edge(1);
        check_entry("idle", '0);

        // preload x1..x31 and then try x0
        model[0] = 32'd0;
        for (int r = 1; r < 32; r++) begin
            wait_edge(0);
            wb.we    = 1'b1;
            wb.rd    = 5'(r);
            wb.data  = $urandom;
            model[r] = wb.data;
        end
        wait_edge(0);
        wb.rd   = 5'd0;
        wb.data = 32'hDEAD_BEEF;
        wait_edge(0);
        wb = '0;

        for (int n = 0; n < vec_inst.size(); n++) begin
            wait_edge(0);
            inst.raw   = vec_inst[n];
            pc         = vec_pc[n];
            inst_valid = 1'b1;
            wait_edge(1);
            check_entry($sformatf("row %0d", n), expect_row(n));
        end

        // same-cycle write to x8 while add reads it
        wait_edge(0);
        fresh      = $urandom;
        inst.raw   = enc_r(7'h00, 9, 8, 3'b000, 7);
        pc         = 32'h200;
        wb.we      = 1'b1;
        wb.rd      = 5'd8;
        wb.data    = fresh;
        model[8]   = fresh;
        wait_edge(1);
        exp = '{1'b1, ctl(0,0,1,1,0, wb_alu, jmp_none, alu_add, size_word, 1), 32'h200,
                fresh, model[9], 32'd0, 5'd7};
        check_entry("bypass", exp);
        wait_edge(0);
        wb = '0;

        // stall three cycles while inst moves on
        for (int k = 0; k < 3; k++) begin
            if (k > 0) wait_edge(0);
            stall    = 1'b1;
            inst.raw = vec_inst[k];
            pc       = vec_pc[k];
            wait_edge(1);
            check_entry("stall", exp);
        end
        wait_edge(0);
        flush = 1'b1; // with stall still high
        wait_edge(1);
        check_entry("flush", '0);

        wait_edge(0);
        flush      = 1'b0;
        stall      = 1'b0;
        inst_valid = 1'b0;
        inst.raw   = vec_inst[0];
        wait_edge(1);
        check_entry("invalid", '0);

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: id_stage.f
+incdir+tb
common/rv_isa_pkg.sv
common/id_ctrl_pkg.sv
id_control/id_control.sv
rtl/id_imm_gen.sv
rtl/id_reg_file.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
tb/id_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the id_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f id_stage.f --top-module id_stage_tb -o id_stage_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/id_stage_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1
